// ==== hw/rd_events_pkg.sv ====
// Read event tracker shared definitions
// Widths, command and statistic encodings, and the structs passed
// between the decode, execute and result stages

package rd_events_pkg;

    // Per-cycle request/response counts and the outstanding-line count
    localparam int READ_CNT_WIDTH = 3;

    // Every statistic is this wide
    localparam int COUNTER_WIDTH = 32;

    // The accumulators are split into two halves of this width
    localparam int COUNTER_HALF = COUNTER_WIDTH / 2;

    // Cycles the snapshot pulse waits for counter updates to land
    localparam int SNAP_DELAY = 3;

    typedef logic [READ_CNT_WIDTH-1:0] read_cnt_t;
    typedef logic [COUNTER_WIDTH-1:0] counter_t;
    typedef logic [COUNTER_HALF-1:0] counter_half_t;

    // Engine commands, valid with cmd_valid
    typedef enum logic [1:0]
    {
        cmd_clear        = 2'd0,
        cmd_snapshot     = 2'd1,
        cmd_cycles_start = 2'd2,
        cmd_cycles_stop  = 2'd3
    } rd_cmd_e;

    // Statistics that the engine can read back
    typedef enum logic [1:0]
    {
        stat_total_lines = 2'd0,
        stat_active_sum  = 2'd1,
        stat_max_active  = 2'd2,
        stat_cycles      = 2'd3
    } rd_stat_e;

    // Registered read counts for one cycle
    typedef struct packed
    {
        read_cnt_t req_cnt;
        read_cnt_t resp_cnt;
    } rd_event_t;

    // Decoded control, pulses except for the enable level
    typedef struct packed
    {
        logic clear;
        logic snapshot;
        logic cycles_en;
    } rd_ctl_t;

    typedef struct packed
    {
        counter_t total_lines;
        counter_t active_sum;
        counter_t max_active;
        counter_t cycles;
    } rd_stats_t;

endpackage

// ==== hw/rd_event_decode.sv ====
// Read event decode stage
// Registers the per-cycle request and response counts and turns the
// engine command strobes into clear and snapshot pulses plus the
// cycle counter enable level

module rd_event_decode
    import rd_events_pkg::*;
(
    input  logic      rdClk,
    input  logic      rd_reset_n,

    input  read_cnt_t rd_req_cnt,
    input  read_cnt_t rd_resp_cnt,

    input  logic      cmd_valid,
    input  rd_cmd_e   cmd_op,

    output rd_event_t event_out,
    output rd_ctl_t   ctl
);

    logic do_clear;
    logic do_snapshot;
    logic do_start;
    logic do_stop;

    // One-hot view of the incoming command
    always_comb
    begin
        do_clear    = 1'b0;
        do_snapshot = 1'b0;
        do_start    = 1'b0;
        do_stop     = 1'b0;

        if (cmd_valid)
        begin
            case (cmd_op)
                cmd_clear:        do_clear    = 1'b1;
                cmd_snapshot:     do_snapshot = 1'b1;
                cmd_cycles_start: do_start    = 1'b1;
                cmd_cycles_stop:  do_stop     = 1'b1;
                default:          ;
            endcase
        end
    end

    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n)
        begin
            event_out <= '0;
            ctl       <= '0;
        end
        else
        begin
            event_out.req_cnt  <= rd_req_cnt;
            event_out.resp_cnt <= rd_resp_cnt;

            ctl.clear    <= do_clear;
            ctl.snapshot <= do_snapshot;

            // Enable holds until stop, and a clear also ends the window
            if (do_start)
            begin
                ctl.cycles_en <= 1'b1;
            end
            else if (do_stop || do_clear)
            begin
                ctl.cycles_en <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/stat_counter.sv ====
// Two-stage wide accumulator
// The low half absorbs the increment first and the registered carry,
// together with the high half of the increment, lands one cycle later.
// The total is exact three cycles after the last increment.

module stat_counter
    import rd_events_pkg::*;
(
    input  logic     rdClk,
    input  logic     rd_reset_n,
    input  logic     clear,
    input  counter_t incr_by,
    output counter_t value
);

    counter_t        incr_q;
    counter_half_t   lo;
    counter_half_t   hi;
    counter_half_t   hi_incr_q;
    logic            carry_q;
    logic [COUNTER_HALF:0] lo_sum;

    assign lo_sum = {1'b0, lo} + {1'b0, incr_q[COUNTER_HALF-1:0]};

    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n || clear)
        begin
            incr_q    <= '0;
            lo        <= '0;
            carry_q   <= 1'b0;
            hi_incr_q <= '0;
            hi        <= '0;
        end
        else
        begin
            // Input register keeps the source fanout off the adder
            incr_q <= incr_by;

            // Stage one
            lo        <= lo_sum[COUNTER_HALF-1:0];
            carry_q   <= lo_sum[COUNTER_HALF];
            hi_incr_q <= incr_q[COUNTER_WIDTH-1:COUNTER_HALF];

            // Stage two
            hi <= hi + hi_incr_q + COUNTER_HALF'(carry_q);
        end
    end

    assign value = {hi, lo};

endmodule

// ==== hw/rd_occupancy_tracker.sv ====
// Read occupancy tracker, execute stage
// Keeps the outstanding-line count and its peak, accumulates total
// requested lines and the outstanding count over time, and counts
// cycles while the engine window is open

module rd_occupancy_tracker
    import rd_events_pkg::*;
(
    input  logic      rdClk,
    input  logic      rd_reset_n,

    input  rd_event_t event_in,
    input  rd_ctl_t   ctl,

    output rd_stats_t stats,
    output logic      snap,
    output logic      not_empty
);

    read_cnt_t active_lines;
    read_cnt_t max_active;
    counter_t  cycles;
    counter_t  total_lines;
    counter_t  active_sum;

    logic [SNAP_DELAY-1:0] snap_pipe;

    // Lines in flight, not touched by clear
    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n)
        begin
            active_lines <= '0;
        end
        else
        begin
            active_lines <= active_lines + event_in.req_cnt - event_in.resp_cnt;
        end
    end

    // Peak of the held outstanding count
    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n || ctl.clear)
        begin
            max_active <= '0;
        end
        else if (active_lines > max_active)
        begin
            max_active <= active_lines;
        end
    end

    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n || ctl.clear)
        begin
            cycles <= '0;
        end
        else if (ctl.cycles_en)
        begin
            cycles <= cycles + counter_t'(1);
        end
    end

    stat_counter total_lines_cnt
    (
        .rdClk      (rdClk),
        .rd_reset_n (rd_reset_n),
        .clear      (ctl.clear),
        .incr_by    (COUNTER_WIDTH'(event_in.req_cnt)),
        .value      (total_lines)
    );

    // Sum of outstanding lines over time, for average latency
    stat_counter active_sum_cnt
    (
        .rdClk      (rdClk),
        .rd_reset_n (rd_reset_n),
        .clear      (ctl.clear),
        .incr_by    (COUNTER_WIDTH'(active_lines)),
        .value      (active_sum)
    );

    // Hold the snapshot back until in-flight counter updates are visible
    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n)
        begin
            snap_pipe <= '0;
        end
        else
        begin
            snap_pipe <= {snap_pipe[SNAP_DELAY-2:0], ctl.snapshot};
        end
    end

    assign snap      = snap_pipe[SNAP_DELAY-1];
    assign not_empty = |active_lines;

    assign stats.total_lines = total_lines;
    assign stats.active_sum  = active_sum;
    assign stats.max_active  = COUNTER_WIDTH'(max_active);
    assign stats.cycles      = cycles;

endmodule

// ==== hw/rd_stats_snapshot.sv ====
// Statistics snapshot, result stage
// Freezes all statistics together on a snapshot pulse so that later
// reads are mutually consistent, and returns one selected statistic
// per read strobe

module rd_stats_snapshot
    import rd_events_pkg::*;
(
    input  logic      rdClk,
    input  logic      rd_reset_n,

    input  rd_stats_t stats,
    input  logic      snap,

    input  logic      stat_rd,
    input  rd_stat_e  stat_sel,

    output logic      stat_valid,
    output counter_t  stat_data
);

    rd_stats_t frozen;
    counter_t  sel_value;

    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n)
        begin
            frozen <= '0;
        end
        else if (snap)
        begin
            frozen <= stats;
        end
    end

    always_comb
    begin
        case (stat_sel)
            stat_total_lines: sel_value = frozen.total_lines;
            stat_active_sum:  sel_value = frozen.active_sum;
            stat_max_active:  sel_value = frozen.max_active;
            stat_cycles:      sel_value = frozen.cycles;
            default:          sel_value = '0;
        endcase
    end

    // One data word and a single-cycle valid per read
    always_ff @(posedge rdClk)
    begin
        if (!rd_reset_n)
        begin
            stat_valid <= 1'b0;
            stat_data  <= '0;
        end
        else
        begin
            stat_valid <= stat_rd;

            if (stat_rd)
            begin
                stat_data <= sel_value;
            end
        end
    end

endmodule

// ==== hw/rd_events_top.sv ====
// Read event tracker top level
// Decode, execute and result stages for one host memory channel,
// all on rdClk

module rd_events_top
    import rd_events_pkg::*;
(
    input  logic      rdClk,
    input  logic      rd_reset_n,

    // Lines issued and returned this cycle, zero when idle
    input  read_cnt_t rd_req_cnt,
    input  read_cnt_t rd_resp_cnt,

    input  logic      cmd_valid,
    input  rd_cmd_e   cmd_op,

    input  logic      stat_rd,
    input  rd_stat_e  stat_sel,

    output logic      not_empty,
    output logic      stat_valid,
    output counter_t  stat_data
);

    rd_event_t event_q;
    rd_ctl_t   ctl;
    rd_stats_t stats;
    logic      snap;

    rd_event_decode decode_i
    (
        .rdClk       (rdClk),
        .rd_reset_n  (rd_reset_n),
        .rd_req_cnt  (rd_req_cnt),
        .rd_resp_cnt (rd_resp_cnt),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .event_out   (event_q),
        .ctl         (ctl)
    );

    rd_occupancy_tracker tracker_i
    (
        .rdClk      (rdClk),
        .rd_reset_n (rd_reset_n),
        .event_in   (event_q),
        .ctl        (ctl),
        .stats      (stats),
        .snap       (snap),
        .not_empty  (not_empty)
    );

    rd_stats_snapshot snapshot_i
    (
        .rdClk      (rdClk),
        .rd_reset_n (rd_reset_n),
        .stats      (stats),
        .snap       (snap),
        .stat_rd    (stat_rd),
        .stat_sel   (stat_sel),
        .stat_valid (stat_valid),
        .stat_data  (stat_data)
    );

endmodule

// ==== test/rd_events_tb.sv ====
// Read event tracker testbench
// Directed tests against a cycle-level reference model of the
// outstanding count, peak, totals and cycle window

module rd_events_tb
    import rd_events_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int RESET_CYCLES = 16;
    // Rough length of all tests in cycles, plus a margin for the watchdog
    localparam int TEST_CYCLES = 1400;
    localparam int MARGIN_CYCLES = 600;

    logic      rdClk;
    logic      rd_reset_n;
    read_cnt_t rd_req_cnt;
    read_cnt_t rd_resp_cnt;
    logic      cmd_valid;
    rd_cmd_e   cmd_op;
    logic      stat_rd;
    rd_stat_e  stat_sel;
    logic      not_empty;
    logic      stat_valid;
    counter_t  stat_data;

    // Reference model state
    int unsigned m_out;
    int unsigned m_peak;
    int unsigned m_total;
    int unsigned m_sum;
    int unsigned m_cycles;
    bit          m_en;

    int errors;

    rd_events_top dut_i
    (
        .rdClk       (rdClk),
        .rd_reset_n  (rd_reset_n),
        .rd_req_cnt  (rd_req_cnt),
        .rd_resp_cnt (rd_resp_cnt),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .stat_rd     (stat_rd),
        .stat_sel    (stat_sel),
        .not_empty   (not_empty),
        .stat_valid  (stat_valid),
        .stat_data   (stat_data)
    );

    always
    begin
        #(CLK_PERIOD / 2) rdClk = ~rdClk;
    end

    // Watchdog
    initial
    begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time, errors so far: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input string what, input int unsigned got,
                               input int unsigned exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // One clock of stimulus, and the matching reference model step
    task automatic drive_cycle(input int unsigned req, input int unsigned resp,
                               input bit cmd_v, input rd_cmd_e op);
        @(posedge rdClk);
        rd_req_cnt  <= read_cnt_t'(req);
        rd_resp_cnt <= read_cnt_t'(resp);
        cmd_valid   <= cmd_v;
        cmd_op      <= op;

        // Sum and peak see the count held before this cycle's update
        m_sum += m_out;
        if (m_out > m_peak)
        begin
            m_peak = m_out;
        end
        m_total += req;
        m_out = m_out + req - resp;
        if (m_en)
        begin
            m_cycles++;
        end

        if (cmd_v)
        begin
            case (op)
                cmd_clear:
                begin
                    m_sum    = 0;
                    m_total  = 0;
                    m_peak   = 0;
                    m_cycles = 0;
                    m_en     = 0;
                end
                cmd_cycles_start: m_en = 1;
                cmd_cycles_stop:  m_en = 0;
                default:          ;
            endcase
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            drive_cycle(0, 0, 1'b0, cmd_clear);
        end
    endtask

    task automatic send_cmd(input rd_cmd_e op);
        drive_cycle(0, 0, 1'b1, op);
    endtask

    // Reads are only issued with no lines outstanding, so the model holds.
    // The valid pulse follows the strobe by one cycle and lasts one cycle
    task automatic read_stat(input rd_stat_e sel, output int unsigned value);
        value = 0;
        @(posedge rdClk);
        rd_req_cnt  <= '0;
        rd_resp_cnt <= '0;
        cmd_valid   <= 1'b0;
        stat_rd     <= 1'b1;
        stat_sel    <= sel;
        @(posedge rdClk);
        stat_rd <= 1'b0;
        @(negedge rdClk);
        if (stat_valid !== 1'b1)
        begin
            $display("No stat_valid pulse came back for a read of %s", sel.name());
            errors++;
        end
        else
        begin
            value = stat_data;
        end
        @(negedge rdClk);
        if (stat_valid !== 1'b0)
        begin
            $display("The stat_valid pulse for a read of %s lasted more than one cycle",
                     sel.name());
            errors++;
        end
    endtask

    task automatic snapshot_and_check(input string tag);
        int unsigned v;

        idle(8);
        send_cmd(cmd_snapshot);
        idle(8);
        read_stat(stat_total_lines, v);
        check_value({tag, " total_lines"}, v, m_total);
        read_stat(stat_active_sum, v);
        check_value({tag, " active_sum"}, v, m_sum);
        read_stat(stat_max_active, v);
        check_value({tag, " max_active"}, v, m_peak);
        read_stat(stat_cycles, v);
        check_value({tag, " cycles"}, v, m_cycles);
    endtask

    task automatic check_not_empty(input string tag, input bit exp);
        @(negedge rdClk);
        if (not_empty !== exp)
        begin
            $display("error at %0t: %s not_empty is %0b, expected %0b",
                     $time, tag, not_empty, exp);
            errors++;
        end
    endtask

    task automatic test_after_reset();
        check_not_empty("reset", 1'b0);
        snapshot_and_check("reset");
    endtask

    task automatic test_burst();
        drive_cycle(3, 0, 1'b0, cmd_clear);
        drive_cycle(2, 0, 1'b0, cmd_clear);
        drive_cycle(2, 0, 1'b0, cmd_clear);
        idle(3);
        check_not_empty("burst", 1'b1);
        drive_cycle(0, 4, 1'b0, cmd_clear);
        drive_cycle(0, 3, 1'b0, cmd_clear);
        idle(1);
        check_not_empty("burst tail", 1'b1);
        idle(2);
        check_not_empty("burst drained", 1'b0);
        snapshot_and_check("burst");
    endtask

    task automatic test_peak();
        int unsigned v;

        send_cmd(cmd_clear);
        drive_cycle(2, 0, 1'b0, cmd_clear);
        drive_cycle(2, 1, 1'b0, cmd_clear);
        drive_cycle(3, 0, 1'b0, cmd_clear);
        drive_cycle(0, 2, 1'b0, cmd_clear);
        drive_cycle(1, 1, 1'b0, cmd_clear);
        drive_cycle(0, 4, 1'b0, cmd_clear);
        snapshot_and_check("peak");
        read_stat(stat_max_active, v);
        check_value("peak max_active", v, 6);
    endtask

    task automatic test_clear_outstanding();
        drive_cycle(4, 0, 1'b0, cmd_clear);
        idle(4);
        send_cmd(cmd_clear);
        idle(4);
        check_not_empty("clear", 1'b1);
        drive_cycle(2, 1, 1'b0, cmd_clear);
        drive_cycle(0, 3, 1'b0, cmd_clear);
        drive_cycle(0, 2, 1'b0, cmd_clear);
        idle(3);
        check_not_empty("clear drained", 1'b0);
        snapshot_and_check("clear");
    endtask

    task automatic test_cycle_window(input int n);
        int unsigned v;

        send_cmd(cmd_clear);
        send_cmd(cmd_cycles_start);
        idle(n - 1);
        send_cmd(cmd_cycles_stop);
        snapshot_and_check("cycles");
        read_stat(stat_cycles, v);
        check_value("cycles window", v, n);
    endtask

    task automatic test_random_traffic();
        int unsigned req;
        int unsigned resp;

        send_cmd(cmd_clear);
        for (int i = 0; i < 300; i++)
        begin
            resp = $urandom % (m_out + 1);
            req  = $urandom % (8 - (m_out - resp));
            drive_cycle(req, resp, 1'b0, cmd_clear);
        end
        drive_cycle(0, m_out, 1'b0, cmd_clear);
        snapshot_and_check("random");
        snapshot_and_check("random again");
    endtask

    initial
    begin
        errors     = 0;
        m_out      = 0;
        m_peak     = 0;
        m_total    = 0;
        m_sum      = 0;
        m_cycles   = 0;
        m_en       = 0;
        void'($urandom(59089));
        rdClk      = 1'b0;
        rd_reset_n = 1'b0;
        rd_req_cnt = '0;
        rd_resp_cnt = '0;
        cmd_valid  = 1'b0;
        cmd_op     = cmd_clear;
        stat_rd    = 1'b0;
        stat_sel   = stat_total_lines;

        repeat (RESET_CYCLES) @(posedge rdClk);
        rd_reset_n <= 1'b1;

        test_after_reset();
        test_burst();
        test_peak();
        test_clear_outstanding();
        test_cycle_window(25);
        test_random_traffic();

        $display("Closing with %0d errors", errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== rd_events.f ====
hw/rd_events_pkg.sv
hw/rd_event_decode.sv
hw/stat_counter.sv
hw/rd_occupancy_tracker.sv
hw/rd_stats_snapshot.sv
hw/rd_events_top.sv
test/rd_events_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wall --top-module rd_events_tb \
		-f rd_events.f -Mdir obj_dir -o Vrd_events_tb

run: compile
	./obj_dir/Vrd_events_tb > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
